// ==== design/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data word, operands and results
`define EXU_WORD_W      32

// shift amount taken from the low bits of source A
`define EXU_SHAMT_W     5

// operation code
`define EXU_OP_W        4

// radix-4 divider, two quotient bits per step
`define EXU_DIV_STEPS   16
`define EXU_DIV_CNT_W   4

`endif

// ==== design/exu_pkg.sv ====
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_WORD_W-1:0]     word_t;
    typedef logic [`EXU_SHAMT_W-1:0]    shamt_t;
    typedef logic [2*`EXU_WORD_W-1:0]   dword_t;    // {remainder, quotient}
    typedef logic [`EXU_DIV_CNT_W-1:0]  step_cnt_t;

    // all operations accepted by the execute unit
    typedef enum logic [`EXU_OP_W-1:0] {
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_LUI,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_DIV,
        OP_DIVU
    } exu_op_e;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DIV_ZERO,
        ST_DIV_RUN,
        ST_DIV_FIX,
        ST_DONE
    } exu_state_e;

endpackage

`default_nettype wire

// ==== design/alu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module alu_core (
    input  wire exu_pkg::exu_op_e op_i,
    input  wire exu_pkg::word_t   src_a_i,
    input  wire exu_pkg::word_t   src_b_i,
    output exu_pkg::word_t        alu_result_o,
    output logic                  ovf_o
);

    import exu_pkg::*;

    localparam int W      = `EXU_WORD_W;
    localparam int HALF_W = `EXU_WORD_W / 2;

    word_t  sum;
    word_t  diff;
    shamt_t shamt;
    logic   add_ovf;
    logic   sub_ovf;
    logic   slt_res;
    logic   sltu_res;

    assign sum   = src_a_i + src_b_i;
    assign diff  = src_a_i - src_b_i;
    assign shamt = src_a_i[`EXU_SHAMT_W-1:0];     // only low bits of A count

    // ************************************************************************
    // signed overflow
    // ************************************************************************

    // add: operands agree in sign but the sum does not
    assign add_ovf = (src_a_i[W-1] == src_b_i[W-1]) &&
                     (sum[W-1] != src_a_i[W-1]);

    // sub: operands differ in sign and the result took the sign of B
    assign sub_ovf = (src_a_i[W-1] != src_b_i[W-1]) &&
                     (diff[W-1] != src_a_i[W-1]);

    assign ovf_o = ((op_i == OP_ADD) && add_ovf) ||
                   ((op_i == OP_SUB) && sub_ovf);  // unsigned forms never flag

    // compares
    assign slt_res  = $signed(src_a_i) < $signed(src_b_i);
    assign sltu_res = src_a_i < src_b_i;

    // ************************************************************************
    // result select
    // ************************************************************************

    always_comb begin
        alu_result_o = '0;
        case (op_i)
            OP_AND:  alu_result_o = src_a_i & src_b_i;
            OP_OR:   alu_result_o = src_a_i | src_b_i;
            OP_XOR:  alu_result_o = src_a_i ^ src_b_i;
            OP_NOR:  alu_result_o = ~(src_a_i | src_b_i);
            OP_LUI: begin
                // low half of B moves up, low half cleared
                alu_result_o = {src_b_i[HALF_W-1:0], {HALF_W{1'b0}}};
            end
            OP_ADD,
            OP_ADDU: alu_result_o = sum;            // wrapped even on overflow
            OP_SUB,
            OP_SUBU: alu_result_o = diff;
            OP_SLT:  alu_result_o = {{(W-1){1'b0}}, slt_res};
            OP_SLTU: alu_result_o = {{(W-1){1'b0}}, sltu_res};
            OP_SLL:  alu_result_o = src_b_i << shamt;
            OP_SRL:  alu_result_o = src_b_i >> shamt;
            OP_SRA:  alu_result_o = word_t'($signed(src_b_i) >>> shamt);  // sign fill
            default: alu_result_o = '0;             // divides go to the divider
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exu_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_ctrl_fsm (
    input  wire                   cpu_clk_50M,
    input  wire                   rst_n_i,
    input  wire                   req_i,
    input  wire exu_pkg::exu_op_e op_i,
    input  wire                   divisor_zero_i,
    input  wire                   cnt_last_i,
    output logic                  ack_o,
    output logic                  div_load_o,
    output logic                  div_flush_o,
    output logic                  div_step_o,
    output logic                  div_fix_o,
    output logic                  cnt_clear_o,
    output logic                  capture_alu_o,
    output logic                  capture_div_o
);

    import exu_pkg::*;

    exu_state_e state_q;
    exu_state_e state_d;
    logic       is_div;
    logic       start;

    assign is_div = (op_i == OP_DIV) || (op_i == OP_DIVU);
    assign start  = (state_q == ST_IDLE) && req_i;     // request sampled

    always_ff @(posedge cpu_clk_50M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ************************************************************************
    // next state
    // ************************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_i) begin
                    if (!is_div) begin
                        state_d = ST_DONE;          // alu result captured now
                    end else if (divisor_zero_i) begin
                        state_d = ST_DIV_ZERO;
                    end else begin
                        state_d = ST_DIV_RUN;
                    end
                end
            end
            ST_DIV_ZERO: state_d = ST_DONE;
            ST_DIV_RUN: begin
                if (cnt_last_i) begin
                    state_d = ST_DIV_FIX;
                end
            end
            ST_DIV_FIX:  state_d = ST_DONE;
            ST_DONE: begin
                if (!req_i) begin
                    state_d = ST_IDLE;              // caller released the request
                end
            end
            default:     state_d = ST_IDLE;
        endcase
    end

    // strobes
    assign capture_alu_o = start && !is_div;
    assign div_load_o    = start && is_div;
    assign cnt_clear_o   = start && is_div;
    assign div_flush_o   = (state_q == ST_DIV_ZERO);
    assign div_step_o    = (state_q == ST_DIV_RUN);
    assign div_fix_o     = (state_q == ST_DIV_FIX);
    assign capture_div_o = div_flush_o || div_fix_o;  // both end a divide
    assign ack_o         = (state_q == ST_DONE);

endmodule

`default_nettype wire

// ==== design/div_step_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module div_step_counter (
    input  wire  cpu_clk_50M,
    input  wire  rst_n_i,
    input  wire  clear_i,
    input  wire  step_i,
    output logic last_o
);

    import exu_pkg::*;

    localparam step_cnt_t LAST_CNT = step_cnt_t'(`EXU_DIV_STEPS - 1);

    step_cnt_t cnt_q;    // steps already taken

    always_ff @(posedge cpu_clk_50M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // high during the final step strobe
    assign last_o = step_i && (cnt_q == LAST_CNT);

endmodule

`default_nettype wire

// ==== design/div_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module div_datapath (
    input  wire                   cpu_clk_50M,
    input  wire                   rst_n_i,
    input  wire exu_pkg::exu_op_e op_i,
    input  wire exu_pkg::word_t   src_a_i,
    input  wire exu_pkg::word_t   src_b_i,
    input  wire                   load_i,
    input  wire                   flush_i,
    input  wire                   step_i,
    input  wire                   fix_i,
    output logic                  divisor_zero_o,
    output exu_pkg::word_t        quotient_o,
    output exu_pkg::word_t        remainder_o
);

    import exu_pkg::*;

    localparam int W = `EXU_WORD_W;

    dword_t       rq_q;          // {partial remainder, dividend/quotient}
    dword_t       rq_d;
    word_t        divisor_q;     // divisor magnitude
    logic         sign_a_q;      // dividend sign, signed divides only
    logic         sign_b_q;      // divisor sign, signed divides only

    logic         is_signed;
    word_t        a_mag;
    word_t        b_mag;
    logic [W+1:0] part;          // remainder with next two dividend bits
    logic [W+1:0] dvs1;
    logic [W+1:0] dvs2;
    logic [W+1:0] dvs3;
    logic [W+2:0] diff1;
    logic [W+2:0] diff2;
    logic [W+2:0] diff3;
    logic [1:0]   q_bits;
    word_t        rem_step;
    word_t        quo_fix;
    word_t        rem_fix;

    // ************************************************************************
    // operand conditioning
    // ************************************************************************

    assign is_signed      = (op_i == OP_DIV);
    assign a_mag          = (is_signed && src_a_i[W-1]) ? -src_a_i : src_a_i;
    assign b_mag          = (is_signed && src_b_i[W-1]) ? -src_b_i : src_b_i;
    assign divisor_zero_o = (src_b_i == '0);

    // ************************************************************************
    // radix-4 step, try 3d, 2d and d
    // ************************************************************************

    assign part = {rq_q[2*W-1:W], rq_q[W-1 -: 2]};
    assign dvs1 = {2'b00, divisor_q};
    assign dvs2 = {1'b0, divisor_q, 1'b0};
    assign dvs3 = dvs1 + dvs2;

    assign diff1 = {1'b0, part} - {1'b0, dvs1};
    assign diff2 = {1'b0, part} - {1'b0, dvs2};
    assign diff3 = {1'b0, part} - {1'b0, dvs3};   // top bit set means negative

    always_comb begin
        if (!diff3[W+2]) begin
            q_bits   = 2'b11;
            rem_step = diff3[W-1:0];
        end else if (!diff2[W+2]) begin
            q_bits   = 2'b10;
            rem_step = diff2[W-1:0];
        end else if (!diff1[W+2]) begin
            q_bits   = 2'b01;
            rem_step = diff1[W-1:0];
        end else begin
            q_bits   = 2'b00;
            rem_step = part[W-1:0];                  // below divisor, fits a word
        end
    end

    // sign fixup, quotient on differing signs, remainder follows the dividend
    assign quo_fix = (sign_a_q ^ sign_b_q) ? -rq_q[W-1:0] : rq_q[W-1:0];
    assign rem_fix = sign_a_q ? -rq_q[2*W-1:W] : rq_q[2*W-1:W];

    always_comb begin
        rq_d = rq_q;
        if (load_i) begin
            rq_d = {{W{1'b0}}, a_mag};
        end else if (flush_i) begin
            rq_d = '0;
        end else if (step_i) begin
            rq_d = {rem_step, rq_q[W-3:0], q_bits};
        end else if (fix_i) begin
            rq_d = {rem_fix, quo_fix};
        end
    end

    always_ff @(posedge cpu_clk_50M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rq_q     <= '0;
            sign_a_q <= 1'b0;
            sign_b_q <= 1'b0;
        end else begin
            rq_q <= rq_d;
            if (load_i) begin
                sign_a_q <= is_signed && src_a_i[W-1];
                sign_b_q <= is_signed && src_b_i[W-1];
            end
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (load_i) begin
            divisor_q <= b_mag;
        end
    end

    // value written by the current strobe, so it is caught on the same edge
    assign quotient_o  = rq_d[W-1:0];
    assign remainder_o = rq_d[2*W-1:W];

endmodule

`default_nettype wire

// ==== design/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  wire                   cpu_clk_50M,
    input  wire                   rst_n_i,
    input  wire                   req_i,
    input  wire exu_pkg::exu_op_e op_i,
    input  wire exu_pkg::word_t   src_a_i,
    input  wire exu_pkg::word_t   src_b_i,
    output logic                  ack_o,
    output exu_pkg::word_t        result_o,
    output exu_pkg::word_t        remainder_o,
    output logic                  ovf_o
);

    import exu_pkg::*;

    logic  div_load;
    logic  div_flush;
    logic  div_step;
    logic  div_fix;
    logic  cnt_clear;
    logic  cnt_last;
    logic  divisor_zero;
    logic  capture_alu;
    logic  capture_div;
    word_t alu_result;
    logic  alu_ovf;
    word_t quotient;
    word_t div_rem;

    // ************************************************************************
    // control, alu and divider
    // ************************************************************************

    exu_ctrl_fsm exu_ctrl_fsm_i (
        .cpu_clk_50M    (cpu_clk_50M),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .op_i           (op_i),
        .divisor_zero_i (divisor_zero),
        .cnt_last_i     (cnt_last),
        .ack_o          (ack_o),
        .div_load_o     (div_load),
        .div_flush_o    (div_flush),
        .div_step_o     (div_step),
        .div_fix_o      (div_fix),
        .cnt_clear_o    (cnt_clear),
        .capture_alu_o  (capture_alu),
        .capture_div_o  (capture_div)
    );

    alu_core alu_core_i (
        .op_i         (op_i),
        .src_a_i      (src_a_i),
        .src_b_i      (src_b_i),
        .alu_result_o (alu_result),
        .ovf_o        (alu_ovf)
    );

    div_step_counter div_step_counter_i (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_n_i     (rst_n_i),
        .clear_i     (cnt_clear),
        .step_i      (div_step),
        .last_o      (cnt_last)
    );

    div_datapath div_datapath_i (
        .cpu_clk_50M    (cpu_clk_50M),
        .rst_n_i        (rst_n_i),
        .op_i           (op_i),
        .src_a_i        (src_a_i),
        .src_b_i        (src_b_i),
        .load_i         (div_load),
        .flush_i        (div_flush),
        .step_i         (div_step),
        .fix_i          (div_fix),
        .divisor_zero_o (divisor_zero),
        .quotient_o     (quotient),
        .remainder_o    (div_rem)
    );

    // output registers, held until the next capture
    always_ff @(posedge cpu_clk_50M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o    <= '0;
            remainder_o <= '0;
            ovf_o       <= 1'b0;
        end else if (capture_alu) begin
            result_o <= alu_result;
            ovf_o    <= alu_ovf;                    // remainder left as is
        end else if (capture_div) begin
            result_o    <= quotient;
            remainder_o <= div_rem;
            ovf_o       <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/exu_ref_model.svh ====
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// expected result_o, worked out on sign-extended 64-bit copies
function automatic word_t alu_or_quotient(input exu_op_e op, input word_t a, input word_t b);
    longint sa;
    longint sb;
    int     sh;

    sa = longint'($signed(a));
    sb = longint'($signed(b));
    sh = a[4:0];                                  // low five bits of A
    case (op)
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_NOR:  return ~(a | b);
        OP_LUI:  return {b[15:0], 16'h0000};
        OP_ADD,
        OP_ADDU: return word_t'(sa + sb);         // low word of the exact sum
        OP_SUB,
        OP_SUBU: return word_t'(sa - sb);
        OP_SLT:  return (sa < sb) ? 32'd1 : 32'd0;
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        OP_SLL:  return word_t'(longint'(b) << sh);
        OP_SRL:  return b >> sh;
        OP_SRA:  return word_t'(sb >>> sh);       // fill from the wide copy
        OP_DIV:  return (b == 32'd0) ? 32'd0 : word_t'(sa / sb);
        OP_DIVU: return (b == 32'd0) ? 32'd0 : a / b;
        default: return 32'd0;
    endcase
endfunction

// remainder takes the dividend's sign on signed divides
function automatic word_t div_remainder(input exu_op_e op, input word_t a, input word_t b);
    if (b == 32'd0) begin
        return 32'd0;
    end
    if (op == OP_DIV) begin
        return word_t'(longint'($signed(a)) % longint'($signed(b)));
    end
    return a % b;
endfunction

// overflow when the exact signed value does not fit one word
function automatic logic signed_overflow(input exu_op_e op, input word_t a, input word_t b);
    longint exact;

    exact = longint'($signed(a));
    if (op == OP_ADD) begin
        exact = exact + longint'($signed(b));
    end else if (op == OP_SUB) begin
        exact = exact - longint'($signed(b));
    end
    return exact != longint'($signed(exact[31:0]));
endfunction

`endif

// ==== tb/tb_exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exu_top;

    import exu_pkg::*;

    `include "exu_ref_model.svh"

    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = NUM_OPS * 25;   // divide with 3 held cycles takes 24

    logic    cpu_clk_50M;
    logic    rst_n_i;
    logic    req_i;
    exu_op_e op_i;
    word_t   src_a_i;
    word_t   src_b_i;
    logic    ack_o;
    word_t   result_o;
    word_t   remainder_o;
    logic    ovf_o;
    int      seed;
    int      cycle_cnt = 0;

    exu_top exu_top_i (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .src_a_i     (src_a_i),
        .src_b_i     (src_b_i),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .remainder_o (remainder_o),
        .ovf_o       (ovf_o)
    );

    always #10 cpu_clk_50M = ~cpu_clk_50M;

    // run limit
    always @(posedge cpu_clk_50M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: request not acknowledged within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // random operands with corner cases mixed in
    task automatic draw_operands(output exu_op_e op, output word_t a, output word_t b);
        op = exu_op_e'($unsigned($random(seed)) % 16);
        a  = $random(seed);
        b  = $random(seed);
        case ($unsigned($random(seed)) % 8)
            0: b = 32'd0;                               // zero divisor
            1: a = 32'h8000_0000;
            2: b = 32'hffff_ffff;
            3: begin
                a = 32'h8000_0000;                      // most negative by minus one
                b = 32'hffff_ffff;
            end
            4: begin
                a = 32'h7fff_ffff;
                b = 32'h7fff_ffff;
            end
            5: b = {27'd0, b[4:0]};                     // small divisor for a long quotient
            default: ;
        endcase
    endtask

    // ************************************************************************
    // one four-phase transfer with checks
    // ************************************************************************

    task automatic run_operation(input exu_op_e op, input word_t a, input word_t b);
        word_t exp_res;
        word_t exp_rem;
        word_t exp_ovf;
        word_t rem_seen;
        int    exp_lat;
        int    lat;
        int    extra;

        exp_res = alu_or_quotient(op, a, b);
        exp_rem = div_remainder(op, a, b);
        exp_ovf = word_t'(signed_overflow(op, a, b));
        exp_lat = 1;
        if ((op == OP_DIV) || (op == OP_DIVU)) begin
            exp_lat = (b == 32'd0) ? 2 : 18;
        end
        extra = $unsigned($random(seed)) % 4;

        @(posedge cpu_clk_50M);
        req_i   <= 1'b1;
        op_i    <= op;
        src_a_i <= a;
        src_b_i <= b;
        @(negedge cpu_clk_50M);
        lat = 0;
        while (!ack_o) begin                            // cycles after req is sampled
            @(negedge cpu_clk_50M);
            lat++;
        end
        check_value("ack latency", lat, exp_lat);
        check_value("result_o", result_o, exp_res);
        check_value("ovf_o", ovf_o, exp_ovf);
        if (exp_lat > 1) begin
            check_value("remainder_o", remainder_o, exp_rem);
        end
        rem_seen = remainder_o;

        repeat (extra) begin                            // caller holds req high
            @(negedge cpu_clk_50M);
            check_value("ack_o", ack_o, 1);
            check_value("result_o", result_o, exp_res);
            check_value("remainder_o", remainder_o, rem_seen);
            check_value("ovf_o", ovf_o, exp_ovf);
        end

        @(posedge cpu_clk_50M);
        req_i <= 1'b0;
        @(negedge cpu_clk_50M);
        check_value("ack_o", ack_o, 1);                 // low req not yet seen
        @(negedge cpu_clk_50M);
        check_value("ack_o", ack_o, 0);
    endtask

    initial begin
        exu_op_e op;
        word_t   a;
        word_t   b;

        cpu_clk_50M = 1'b0;
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        op_i        = OP_AND;
        src_a_i     = 32'd0;
        src_b_i     = 32'd0;
        seed        = 32'h137d2d3b;

        repeat (3) @(posedge cpu_clk_50M);
        rst_n_i <= 1'b1;
        @(negedge cpu_clk_50M);
        check_value("ack_o", ack_o, 0);
        check_value("result_o", result_o, 0);
        check_value("remainder_o", remainder_o, 0);
        check_value("ovf_o", ovf_o, 0);

        for (int i = 0; i < NUM_OPS; i++) begin
            draw_operands(op, a, b);
            run_operation(op, a, b);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
+incdir+tb
design/exu_pkg.sv
design/alu_core.sv
design/exu_ctrl_fsm.sv
design/div_step_counter.sv
design/div_datapath.sv
design/exu_top.sv
tb/tb_exu_top.sv
